// File: id_stage.f
source/id_isa_pkg.sv
source/id_ctrl_pkg.sv
source/id_decode_if.sv
source/id_regfile.sv
source/id_decoder.sv
source/id_issue.sv
source/id_stage.sv
verif/tb_clk_gen.sv
verif/id_stage_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the decode stage testbench with Verilator from the project root.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --timescale 1ns/1ps --top-module id_stage_tb \
  -f id_stage.f -o id_stage_sim > build.log 2>&1 || { cat build.log; echo "Build error"; exit 1; }

./obj_dir/id_stage_sim > sim.log 2>&1
cat sim.log

grep -q "tests failed" sim.log && { echo "Result: fail"; exit 1; }
grep -q "all tests passed" sim.log || { echo "Result: run ended early"; exit 1; }
echo "Result: pass"

// File: source/id_ctrl_pkg.sv
// Control types of the decode stage.
// Enum encodings are sequential from zero in the order listed.
package id_ctrl_pkg;

  typedef enum logic [4:0] {
    ALU_ADD = 5'd0,
    ALU_SUB,
    ALU_XOR,
    ALU_OR,
    ALU_AND,
    // Shifts
    ALU_SRA,
    ALU_SRL,
    ALU_SLL,
    // Set less than
    ALU_SLT,
    ALU_SLTU,
    // Branch compares
    ALU_EQ,
    ALU_NE,
    ALU_LT,
    ALU_GE,
    ALU_LTU,
    ALU_GEU
  } alu_op_e;

  typedef enum logic [1:0] {
    OP_A_REG_A,
    OP_A_FWD,
    OP_A_CURRPC,
    OP_A_IMM
  } op_a_sel_e;

  typedef enum logic {
    OP_B_REG_B,
    OP_B_IMM
  } op_b_sel_e;

  typedef enum logic [2:0] {
    IMM_B_I,
    IMM_B_S,
    IMM_B_B,
    IMM_B_U,
    IMM_B_J,
    IMM_B_INCR_PC,
    IMM_B_INCR_ADDR
  } imm_b_sel_e;

  typedef enum logic [2:0] {
    CSR_OP_NONE,
    CSR_OP_READ,
    CSR_OP_WRITE,
    CSR_OP_SET,
    CSR_OP_CLEAR
  } csr_op_e;

  typedef enum logic {
    ISSUE_IDLE,
    ISSUE_WAIT
  } issue_state_e;

endpackage

// File: source/id_decode_if.sv
`timescale 1ns/1ps
// Decoded controls and immediates of the current instruction word.
// All values are combinational. There is no handshake.
// Write and request flags arrive already gated by valid and legality.
interface id_decode_if
  import id_isa_pkg::*;
  import id_ctrl_pkg::*;
();

  alu_op_e    alu_operator;
  op_a_sel_e  op_a_sel;
  op_b_sel_e  op_b_sel;
  imm_b_sel_e imm_b_sel;

  word_t imm_i;
  word_t imm_s;
  word_t imm_b;
  word_t imm_u;
  word_t imm_j;
  // CSR immediate, zero for every other instruction
  word_t zimm;

  logic    rf_we;
  logic    data_req;
  logic    data_we;
  logic    jump;
  logic    branch;
  logic    csr_access;
  csr_op_e csr_op;
  logic    rs1_zero;

  modport decoder (
    output alu_operator, op_a_sel, op_b_sel, imm_b_sel,
    output imm_i, imm_s, imm_b, imm_u, imm_j, zimm,
    output rf_we, data_req, data_we, jump, branch, csr_access, csr_op, rs1_zero
  );

  modport issue (
    input alu_operator, op_a_sel, op_b_sel, imm_b_sel,
    input imm_i, imm_s, imm_b, imm_u, imm_j, zimm,
    input rf_we, data_req, data_we, jump, branch, csr_access, csr_op, rs1_zero
  );

endinterface

// File: source/id_decoder.sv
`timescale 1ns/1ps
// Compact RV32I decoder for OP, OP-IMM, LUI, AUIPC, JAL, JALR, BRANCH,
// LOAD, STORE and the six Zicsr instructions.
// FENCE, ECALL, EBREAK, MRET and compressed forms decode as illegal.
// Under RV32E an index of 16 or more in a used register field is illegal.
module id_decoder
  import id_isa_pkg::*;
  import id_ctrl_pkg::*;
#(
  parameter bit RV32E = 1'b0
) (
  input  logic                instr_valid_i,
  input  word_t               instr_i,
  output logic                illegal_insn_o,
  output reg_addr_t           rs1_addr_o,
  output reg_addr_t           rs2_addr_o,
  output reg_addr_t           rd_addr_o,
  id_decode_if.decoder        dec
);

  opcode_e    opcode;
  funct3_t    funct3;
  funct7_t    funct7;
  alu_op_e    alu_op;
  op_a_sel_e  op_a;
  op_b_sel_e  op_b;
  imm_b_sel_e imm_sel;
  csr_op_e    csr_op;
  word_t      zimm;
  logic       rf_we;
  logic       data_req;
  logic       data_we;
  logic       jump;
  logic       branch;
  logic       csr_access;
  logic       illegal_opc;
  logic       illegal_reg;
  logic       issue_ok;

  assign opcode     = opcode_e'(instr_i[6:0]);
  assign funct3     = instr_i[14:12];
  assign funct7     = instr_i[31:25];
  assign rs1_addr_o = instr_i[RegS1Lsb +: 5];
  assign rs2_addr_o = instr_i[RegS2Lsb +: 5];
  assign rd_addr_o  = instr_i[RegDLsb +: 5];

  //////////////////////////////////////////////////
  // Opcode decode
  //////////////////////////////////////////////////

  always_comb begin
    alu_op      = ALU_ADD;
    op_a        = OP_A_REG_A;
    op_b        = OP_B_IMM;
    imm_sel     = IMM_B_I;
    csr_op      = CSR_OP_NONE;
    zimm        = '0;
    rf_we       = 1'b0;
    data_req    = 1'b0;
    data_we     = 1'b0;
    jump        = 1'b0;
    branch      = 1'b0;
    csr_access  = 1'b0;
    illegal_opc = 1'b0;

    unique case (opcode)
      OPC_LUI: begin
        // Zero on operand A plus the U immediate
        op_a    = OP_A_IMM;
        imm_sel = IMM_B_U;
        rf_we   = 1'b1;
      end
      OPC_AUIPC: begin
        op_a    = OP_A_CURRPC;
        imm_sel = IMM_B_U;
        rf_we   = 1'b1;
      end
      OPC_JAL: begin
        op_a    = OP_A_CURRPC;
        imm_sel = IMM_B_J;
        jump    = 1'b1;
        rf_we   = 1'b1;
      end
      OPC_JALR: begin
        jump        = 1'b1;
        rf_we       = 1'b1;
        illegal_opc = (funct3 != 3'd0);
      end
      OPC_BRANCH: begin
        // Compare first, target later in the issue unit
        op_b    = OP_B_REG_B;
        imm_sel = IMM_B_B;
        branch  = 1'b1;
        unique case (funct3)
          3'd0:    alu_op = ALU_EQ;
          3'd1:    alu_op = ALU_NE;
          3'd4:    alu_op = ALU_LT;
          3'd5:    alu_op = ALU_GE;
          3'd6:    alu_op = ALU_LTU;
          3'd7:    alu_op = ALU_GEU;
          default: illegal_opc = 1'b1;
        endcase
      end
      OPC_LOAD: begin
        data_req    = 1'b1;
        rf_we       = 1'b1;
        illegal_opc = (funct3 == 3'd3) || (funct3 == 3'd6) || (funct3 == 3'd7);
      end
      OPC_STORE: begin
        imm_sel     = IMM_B_S;
        data_req    = 1'b1;
        data_we     = 1'b1;
        illegal_opc = (funct3 > 3'd2);
      end
      OPC_OP_IMM: begin
        rf_we = 1'b1;
        unique case (funct3)
          3'd0: alu_op = ALU_ADD;
          3'd2: alu_op = ALU_SLT;
          3'd3: alu_op = ALU_SLTU;
          3'd4: alu_op = ALU_XOR;
          3'd6: alu_op = ALU_OR;
          3'd7: alu_op = ALU_AND;
          3'd1: begin
            alu_op      = ALU_SLL;
            illegal_opc = (funct7 != 7'h00);
          end
          default: begin
            // Bit 30 picks arithmetic shift
            alu_op      = funct7[5] ? ALU_SRA : ALU_SRL;
            illegal_opc = ({funct7[6], funct7[4:0]} != 6'd0);
          end
        endcase
      end
      OPC_OP: begin
        op_b  = OP_B_REG_B;
        rf_we = 1'b1;
        unique case ({funct7, funct3})
          {7'h00, 3'd0}: alu_op = ALU_ADD;
          {7'h20, 3'd0}: alu_op = ALU_SUB;
          {7'h00, 3'd1}: alu_op = ALU_SLL;
          {7'h00, 3'd2}: alu_op = ALU_SLT;
          {7'h00, 3'd3}: alu_op = ALU_SLTU;
          {7'h00, 3'd4}: alu_op = ALU_XOR;
          {7'h00, 3'd5}: alu_op = ALU_SRL;
          {7'h20, 3'd5}: alu_op = ALU_SRA;
          {7'h00, 3'd6}: alu_op = ALU_OR;
          {7'h00, 3'd7}: alu_op = ALU_AND;
          default:       illegal_opc = 1'b1;
        endcase
      end
      OPC_SYSTEM: begin
        // CSR address travels on operand B as the I immediate
        csr_access = 1'b1;
        rf_we      = 1'b1;
        if (funct3[2]) begin
          op_a = OP_A_IMM;
          zimm = word_t'(rs1_addr_o);
        end
        unique case (funct3[1:0])
          2'd1:    csr_op = CSR_OP_WRITE;
          2'd2:    csr_op = CSR_OP_SET;
          2'd3:    csr_op = CSR_OP_CLEAR;
          default: illegal_opc = 1'b1;
        endcase
      end
      default: illegal_opc = 1'b1;
    endcase
  end

  // A field counts only if the instruction reads or writes it
  assign illegal_reg = RV32E && (((op_a == OP_A_REG_A) && rs1_addr_o[4]) ||
                                 ((op_b == OP_B_REG_B || data_we) && rs2_addr_o[4]) ||
                                 (rf_we && rd_addr_o[4]));

  assign illegal_insn_o = illegal_opc | illegal_reg;
  assign issue_ok       = instr_valid_i & ~illegal_insn_o;

  //////////////////////////////////////////////////
  // Outputs to the issue unit
  //////////////////////////////////////////////////

  assign dec.alu_operator = alu_op;
  assign dec.op_a_sel     = op_a;
  assign dec.op_b_sel     = op_b;
  assign dec.imm_b_sel    = imm_sel;
  assign dec.imm_i        = imm_i_ext(instr_i);
  assign dec.imm_s        = imm_s_ext(instr_i);
  assign dec.imm_b        = imm_b_ext(instr_i);
  assign dec.imm_u        = imm_u_ext(instr_i);
  assign dec.imm_j        = imm_j_ext(instr_i);
  assign dec.zimm         = zimm;
  assign dec.rf_we        = rf_we & issue_ok;
  assign dec.data_req     = data_req & issue_ok;
  assign dec.data_we      = data_we & issue_ok;
  assign dec.jump         = jump & issue_ok;
  assign dec.branch       = branch & issue_ok;
  assign dec.csr_access   = csr_access & issue_ok;
  assign dec.csr_op       = csr_op;
  assign dec.rs1_zero     = (rs1_addr_o == '0);

endmodule

// File: source/id_isa_pkg.sv
// RV32I instruction-set types for the decode stage.
// Only the opcodes the stage decodes are named. Any other value is illegal.
// Immediate helpers return sign-extended words per the base ISA formats.
package id_isa_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [2:0]  funct3_t;
  typedef logic [6:0]  funct7_t;

  typedef enum logic [6:0] {
    OPC_LOAD   = 7'h03,
    OPC_OP_IMM = 7'h13,
    OPC_AUIPC  = 7'h17,
    OPC_STORE  = 7'h23,
    OPC_OP     = 7'h33,
    OPC_LUI    = 7'h37,
    OPC_BRANCH = 7'h63,
    OPC_JALR   = 7'h67,
    OPC_JAL    = 7'h6f,
    OPC_SYSTEM = 7'h73
  } opcode_e;

  // Register field positions in the instruction word
  localparam int unsigned RegS1Lsb = 15;
  localparam int unsigned RegS2Lsb = 20;
  localparam int unsigned RegDLsb  = 7;

  function automatic word_t imm_i_ext(word_t instr);
    return {{20{instr[31]}}, instr[31:20]};
  endfunction

  function automatic word_t imm_s_ext(word_t instr);
    return {{20{instr[31]}}, instr[31:25], instr[11:7]};
  endfunction

  function automatic word_t imm_b_ext(word_t instr);
    return {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  endfunction

  function automatic word_t imm_u_ext(word_t instr);
    return {instr[31:12], 12'b0};
  endfunction

  function automatic word_t imm_j_ext(word_t instr);
    return {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
  endfunction

endpackage

// File: source/id_issue.sv
`timescale 1ns/1ps
// Operand selection, write-back select and the multicycle issue machine.
// Loads, stores, jumps and taken branches hold id_ready_o low until
// ex_ready_i is seen high in the wait state.
// In the wait state a branch or jump shows PC based math on the ALU:
// the branch target, or the link address for a jump.
module id_issue
  import id_isa_pkg::*;
  import id_ctrl_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_ni,
  id_decode_if.issue   dec,
  input  reg_addr_t    rd_addr_i,
  input  word_t        rdata_a_i,
  input  word_t        rdata_b_i,
  input  word_t        pc_id_i,
  input  word_t        lsu_addr_last_i,
  input  word_t        regfile_wdata_lsu_i,
  input  word_t        regfile_wdata_ex_i,
  input  word_t        csr_rdata_i,
  input  logic         instr_is_compressed_i,
  input  logic         data_misaligned_i,
  input  logic         branch_decision_i,
  input  logic         ex_ready_i,
  output reg_addr_t    rf_waddr_o,
  output word_t        rf_wdata_o,
  output logic         rf_we_o,
  output logic         id_ready_o,
  output alu_op_e      alu_operator_o,
  output word_t        alu_operand_a_o,
  output word_t        alu_operand_b_o,
  output logic         data_req_o,
  output logic         data_we_o,
  output word_t        data_wdata_o,
  output logic         csr_access_o,
  output csr_op_e      csr_op_o
);

  issue_state_e state_q;
  issue_state_e state_d;
  op_a_sel_e    op_a_sel;
  op_b_sel_e    op_b_sel;
  imm_b_sel_e   imm_b_sel;
  word_t        imm_b;
  logic         rf_we;
  logic         sel_lsu;

  //////////////////////////////////////////////////
  // Operand select overrides
  //////////////////////////////////////////////////

  always_comb begin
    alu_operator_o = dec.alu_operator;
    op_a_sel       = dec.op_a_sel;
    op_b_sel       = dec.op_b_sel;
    imm_b_sel      = dec.imm_b_sel;
    if (data_misaligned_i) begin
      // Second half of a split access, address plus 4
      op_a_sel  = OP_A_FWD;
      op_b_sel  = OP_B_IMM;
      imm_b_sel = IMM_B_INCR_ADDR;
    end else if ((state_q == ISSUE_WAIT) && (dec.branch || dec.jump)) begin
      alu_operator_o = ALU_ADD;
      op_a_sel       = OP_A_CURRPC;
      op_b_sel       = OP_B_IMM;
      imm_b_sel      = dec.branch ? IMM_B_B : IMM_B_INCR_PC;
    end
  end

  always_comb begin
    unique case (op_a_sel)
      OP_A_REG_A:  alu_operand_a_o = rdata_a_i;
      OP_A_FWD:    alu_operand_a_o = lsu_addr_last_i;
      OP_A_CURRPC: alu_operand_a_o = pc_id_i;
      default:     alu_operand_a_o = dec.zimm;
    endcase
  end

  always_comb begin
    unique case (imm_b_sel)
      IMM_B_I:       imm_b = dec.imm_i;
      IMM_B_S:       imm_b = dec.imm_s;
      IMM_B_B:       imm_b = dec.imm_b;
      IMM_B_U:       imm_b = dec.imm_u;
      IMM_B_J:       imm_b = dec.imm_j;
      IMM_B_INCR_PC: imm_b = instr_is_compressed_i ? 32'd2 : 32'd4;
      default:       imm_b = 32'd4;
    endcase
  end

  assign alu_operand_b_o = (op_b_sel == OP_B_IMM) ? imm_b : rdata_b_i;

  // Set or clear from x0 or a zero immediate leaves the CSR untouched
  always_comb begin
    csr_op_o = dec.csr_op;
    if ((dec.csr_op == CSR_OP_SET || dec.csr_op == CSR_OP_CLEAR) && dec.rs1_zero) begin
      csr_op_o = CSR_OP_READ;
    end
  end

  assign data_req_o   = dec.data_req;
  assign data_we_o    = dec.data_we;
  assign data_wdata_o = rdata_b_i;
  assign csr_access_o = dec.csr_access;

  //////////////////////////////////////////////////
  // Multicycle issue FSM
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ISSUE_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d    = state_q;
    id_ready_o = 1'b1;
    rf_we      = dec.rf_we;
    sel_lsu    = 1'b0;
    unique case (state_q)
      ISSUE_IDLE: begin
        if (dec.data_req || dec.jump || (dec.branch && branch_decision_i)) begin
          state_d    = ISSUE_WAIT;
          id_ready_o = 1'b0;
          rf_we      = 1'b0;
        end
      end
      default: begin
        if (ex_ready_i) begin
          state_d = ISSUE_IDLE;
          sel_lsu = dec.data_req;
        end else begin
          id_ready_o = 1'b0;
          rf_we      = 1'b0;
        end
      end
    endcase
  end

  // Write-back source and port
  always_comb begin
    if (sel_lsu) begin
      rf_wdata_o = regfile_wdata_lsu_i;
    end else if (dec.csr_access) begin
      rf_wdata_o = csr_rdata_i;
    end else begin
      rf_wdata_o = regfile_wdata_ex_i;
    end
  end

  assign rf_waddr_o = rd_addr_i;
  assign rf_we_o    = rf_we & ~data_misaligned_i;

endmodule

// File: source/id_regfile.sv
`timescale 1ns/1ps
// Two asynchronous read ports, one synchronous write port.
// x0 reads as zero and ignores writes.
// With RV32E only the low four address bits are used. Indices of 16 or
// more must be caught as illegal before they reach this block.
module id_regfile
  import id_isa_pkg::*;
#(
  parameter bit RV32E = 1'b0
) (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  reg_addr_t raddr_a_i,
  input  reg_addr_t raddr_b_i,
  input  reg_addr_t waddr_i,
  input  word_t     wdata_i,
  input  logic      we_i,
  output word_t     rdata_a_o,
  output word_t     rdata_b_o
);

  localparam int unsigned AddrW   = RV32E ? 4 : 5;
  localparam int unsigned NumRegs = 2 ** AddrW;

  logic [AddrW-1:0] ra;
  logic [AddrW-1:0] rb;
  logic [AddrW-1:0] wa;
  word_t            regs [NumRegs];

  assign ra = raddr_a_i[AddrW-1:0];
  assign rb = raddr_b_i[AddrW-1:0];
  assign wa = waddr_i[AddrW-1:0];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < NumRegs; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && (wa != '0)) begin
      regs[wa] <= wdata_i;
    end
  end

  // Hard-wired zero on both read ports
  assign rdata_a_o = (ra == '0) ? '0 : regs[ra];
  assign rdata_b_o = (rb == '0) ? '0 : regs[rb];

endmodule

// File: source/id_stage.sv
`timescale 1ns/1ps
// RV32I instruction decode stage.
// Only one instruction is in flight. The source holds the instruction
// until id_ready_o is high. No controller, interrupts, debug or RV32M.
module id_stage
  import id_isa_pkg::*;
  import id_ctrl_pkg::*;
#(
  parameter bit RV32E = 1'b0
) (
  input  logic    clk_i,
  input  logic    rst_ni,
  input  logic    instr_valid_i,
  input  word_t   instr_rdata_i,
  input  logic    instr_is_compressed_i,
  input  word_t   pc_id_i,
  input  logic    branch_decision_i,
  input  logic    ex_ready_i,
  input  logic    data_misaligned_i,
  input  word_t   lsu_addr_last_i,
  input  word_t   regfile_wdata_lsu_i,
  input  word_t   regfile_wdata_ex_i,
  input  word_t   csr_rdata_i,
  output logic    id_ready_o,
  output logic    illegal_insn_o,
  output alu_op_e alu_operator_o,
  output word_t   alu_operand_a_o,
  output word_t   alu_operand_b_o,
  output logic    data_req_o,
  output logic    data_we_o,
  output word_t   data_wdata_o,
  output logic    csr_access_o,
  output csr_op_e csr_op_o
);

  reg_addr_t rs1_addr;
  reg_addr_t rs2_addr;
  reg_addr_t rd_addr;
  reg_addr_t rf_waddr;
  word_t     rdata_a;
  word_t     rdata_b;
  word_t     rf_wdata;
  logic      rf_we;

  id_decode_if dec_if ();

  id_decoder #(
    .RV32E (RV32E)
  ) u_decoder (
    .instr_valid_i  (instr_valid_i),
    .instr_i        (instr_rdata_i),
    .illegal_insn_o (illegal_insn_o),
    .rs1_addr_o     (rs1_addr),
    .rs2_addr_o     (rs2_addr),
    .rd_addr_o      (rd_addr),
    .dec            (dec_if.decoder)
  );

  id_regfile #(
    .RV32E (RV32E)
  ) u_regfile (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .raddr_a_i (rs1_addr),
    .raddr_b_i (rs2_addr),
    .waddr_i   (rf_waddr),
    .wdata_i   (rf_wdata),
    .we_i      (rf_we),
    .rdata_a_o (rdata_a),
    .rdata_b_o (rdata_b)
  );

  id_issue u_issue (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .dec                   (dec_if.issue),
    .rd_addr_i             (rd_addr),
    .rdata_a_i             (rdata_a),
    .rdata_b_i             (rdata_b),
    .pc_id_i               (pc_id_i),
    .lsu_addr_last_i       (lsu_addr_last_i),
    .regfile_wdata_lsu_i   (regfile_wdata_lsu_i),
    .regfile_wdata_ex_i    (regfile_wdata_ex_i),
    .csr_rdata_i           (csr_rdata_i),
    .instr_is_compressed_i (instr_is_compressed_i),
    .data_misaligned_i     (data_misaligned_i),
    .branch_decision_i     (branch_decision_i),
    .ex_ready_i            (ex_ready_i),
    .rf_waddr_o            (rf_waddr),
    .rf_wdata_o            (rf_wdata),
    .rf_we_o               (rf_we),
    .id_ready_o            (id_ready_o),
    .alu_operator_o        (alu_operator_o),
    .alu_operand_a_o       (alu_operand_a_o),
    .alu_operand_b_o       (alu_operand_b_o),
    .data_req_o            (data_req_o),
    .data_we_o             (data_we_o),
    .data_wdata_o          (data_wdata_o),
    .csr_access_o          (csr_access_o),
    .csr_op_o              (csr_op_o)
  );

endmodule

// File: verif/id_stage_tb.sv
`timescale 1ns/1ps
// Testbench for the decode stage, RV32E off.
// Each vector line is one clock cycle. Inputs change on the falling edge
// and outputs are sampled a few ns later, before the next rising edge.
// lsu_addr_last_i and instr_is_compressed_i are held constant.
// The first mismatch stops the run.
module id_stage_tb
  import id_isa_pkg::*;
  import id_ctrl_pkg::*;
();

  localparam string       VecFile     = "verif/id_stage_vectors.txt";
  localparam int unsigned NumCols     = 18;
  localparam int unsigned SettleNs    = 2;
  localparam word_t       LsuAddrLast = 32'h0000_1ffe;

  // Base ISA major opcodes of the store and system groups
  localparam logic [6:0] StoreOpcode  = 7'b010_0011;
  localparam logic [6:0] SystemOpcode = 7'b111_0011;

  typedef struct {
    string      name;
    word_t      instr;
    word_t      pc;
    logic       valid;
    logic       misaligned;
    logic       branch_taken;
    logic       ex_ready;
    word_t      lsu_data;
    word_t      ex_data;
    word_t      csr_data;
    alu_op_e    exp_op;
    word_t      exp_a;
    word_t      exp_b;
    logic       exp_req;
    word_t      exp_wdata;
    csr_op_e    exp_csr;
    logic       exp_ready;
    logic       exp_illegal;
    logic [7:0] mask;
  } vector_t;

  logic    clk;
  logic    rst_n;
  logic    instr_valid;
  word_t   instr_rdata;
  logic    instr_compressed;
  word_t   pc_id;
  logic    branch_decision;
  logic    ex_ready;
  logic    data_misaligned;
  word_t   lsu_addr_last;
  word_t   wdata_lsu;
  word_t   wdata_ex;
  word_t   csr_rdata;
  logic    id_ready;
  logic    illegal_insn;
  alu_op_e alu_operator;
  word_t   operand_a;
  word_t   operand_b;
  logic    data_req;
  logic    data_we;
  word_t   data_wdata;
  logic    csr_access;
  csr_op_e csr_op;

  vector_t vectors[$];
  int      cycle_count = 0;
  int      cycle_limit = 0;
  int      check_count = 0;

  tb_clk_gen u_clk_gen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  id_stage #(
    .RV32E (1'b0)
  ) uut (
    .clk_i                 (clk),
    .rst_ni                (rst_n),
    .instr_valid_i         (instr_valid),
    .instr_rdata_i         (instr_rdata),
    .instr_is_compressed_i (instr_compressed),
    .pc_id_i               (pc_id),
    .branch_decision_i     (branch_decision),
    .ex_ready_i            (ex_ready),
    .data_misaligned_i     (data_misaligned),
    .lsu_addr_last_i       (lsu_addr_last),
    .regfile_wdata_lsu_i   (wdata_lsu),
    .regfile_wdata_ex_i    (wdata_ex),
    .csr_rdata_i           (csr_rdata),
    .id_ready_o            (id_ready),
    .illegal_insn_o        (illegal_insn),
    .alu_operator_o        (alu_operator),
    .alu_operand_a_o       (operand_a),
    .alu_operand_b_o       (operand_b),
    .data_req_o            (data_req),
    .data_we_o             (data_we),
    .data_wdata_o          (data_wdata),
    .csr_access_o          (csr_access),
    .csr_op_o              (csr_op)
  );

  //////////////////////////////////////////////////
  // Failure handling and compare tasks
  //////////////////////////////////////////////////

  task automatic abort_run();
    $display("tests failed");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_word(input string test, input string field,
                            input word_t exp, input word_t act);
    check_count++;
    if (act !== exp) begin
      $display("FAILED %s %s expected %h actual %h", test, field, exp, act);
      abort_run();
    end
  endtask

  task automatic check_alu_op(input string test, input string field,
                              input alu_op_e exp, input alu_op_e act);
    check_count++;
    if (act !== exp) begin
      $display("FAILED %s %s expected %s (%0h) actual %s (%0h)",
               test, field, exp.name(), exp, act.name(), act);
      abort_run();
    end
  endtask

  task automatic check_csr_op(input string test, input string field,
                              input csr_op_e exp, input csr_op_e act);
    check_count++;
    if (act !== exp) begin
      $display("FAILED %s %s expected %s (%0h) actual %s (%0h)",
               test, field, exp.name(), exp, act.name(), act);
      abort_run();
    end
  endtask

  task automatic check_bit(input string test, input string field,
                           input logic exp, input logic act);
    check_count++;
    if (act !== exp) begin
      $display("FAILED %s %s expected %b actual %b", test, field, exp, act);
      abort_run();
    end
  endtask

  //////////////////////////////////////////////////
  // Vector file
  //////////////////////////////////////////////////

  // Lines starting with # and empty lines carry no vector
  function automatic bit is_data_line(input string line);
    logic [7:0] first;
    if (line.len() == 0) begin
      return 1'b0;
    end
    first = line.getc(0);
    return (first != "#") && (first != "\n") && (first != "\r");
  endfunction

  task automatic load_vectors();
    int      fd;
    int      fields;
    string   line;
    string   name;
    word_t   col [NumCols];
    vector_t vec;
    fd = $fopen(VecFile, "r");
    if (fd == 0) begin
      $display("cannot open vector file %s", VecFile);
      abort_run();
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (is_data_line(line)) begin
          fields = $sscanf(line,
            "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h", name,
            col[0], col[1], col[2], col[3], col[4], col[5], col[6], col[7], col[8],
            col[9], col[10], col[11], col[12], col[13], col[14], col[15], col[16],
            col[17]);
          if (fields != NumCols + 1) begin
            $display("malformed vector line: %s", line);
            abort_run();
          end else begin
            vec.name         = name;
            vec.instr        = col[0];
            vec.pc           = col[1];
            vec.valid        = col[2][0];
            vec.misaligned   = col[3][0];
            vec.branch_taken = col[4][0];
            vec.ex_ready     = col[5][0];
            vec.lsu_data     = col[6];
            vec.ex_data      = col[7];
            vec.csr_data     = col[8];
            vec.exp_op       = alu_op_e'(col[9][4:0]);
            vec.exp_a        = col[10];
            vec.exp_b        = col[11];
            vec.exp_req      = col[12][0];
            vec.exp_wdata    = col[13];
            vec.exp_csr      = csr_op_e'(col[14][2:0]);
            vec.exp_ready    = col[15][0];
            vec.exp_illegal  = col[16][0];
            vec.mask         = col[17][7:0];
            vectors.push_back(vec);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  //////////////////////////////////////////////////
  // Drive and check one cycle
  //////////////////////////////////////////////////

  task automatic apply_vector(input vector_t vec);
    instr_valid     = vec.valid;
    instr_rdata     = vec.instr;
    pc_id           = vec.pc;
    data_misaligned = vec.misaligned;
    branch_decision = vec.branch_taken;
    ex_ready        = vec.ex_ready;
    wdata_lsu       = vec.lsu_data;
    wdata_ex        = vec.ex_data;
    csr_rdata       = vec.csr_data;
  endtask

  task automatic check_vector(input vector_t vec);
    logic issued;
    logic exp_we;
    logic exp_access;
    // Store and CSR flags drop for an invalid or illegal instruction
    issued     = vec.valid && !vec.exp_illegal;
    exp_we     = issued && (vec.instr[6:0] == StoreOpcode);
    exp_access = issued && (vec.instr[6:0] == SystemOpcode);
    if (vec.mask[0]) check_alu_op(vec.name, "alu_operator_o", vec.exp_op, alu_operator);
    if (vec.mask[1]) check_word(vec.name, "alu_operand_a_o", vec.exp_a, operand_a);
    if (vec.mask[2]) check_word(vec.name, "alu_operand_b_o", vec.exp_b, operand_b);
    if (vec.mask[3]) check_bit(vec.name, "data_req_o", vec.exp_req, data_req);
    if (vec.mask[4]) check_word(vec.name, "data_wdata_o", vec.exp_wdata, data_wdata);
    if (vec.mask[5]) check_csr_op(vec.name, "csr_op_o", vec.exp_csr, csr_op);
    if (vec.mask[6]) check_bit(vec.name, "id_ready_o", vec.exp_ready, id_ready);
    if (vec.mask[7]) check_bit(vec.name, "illegal_insn_o", vec.exp_illegal, illegal_insn);
    check_bit(vec.name, "data_we_o", exp_we, data_we);
    check_bit(vec.name, "csr_access_o", exp_access, csr_access);
  endtask

  // Watchdog over the whole run, reset included
  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if ((cycle_limit > 0) && (cycle_count > cycle_limit)) begin
      $display("timeout after %0d cycles before all vectors were applied", cycle_count);
      abort_run();
    end
  end

  initial begin
    instr_valid      = 1'b0;
    instr_rdata      = '0;
    instr_compressed = 1'b0;
    pc_id            = '0;
    branch_decision  = 1'b0;
    ex_ready         = 1'b0;
    data_misaligned  = 1'b0;
    lsu_addr_last    = LsuAddrLast;
    wdata_lsu        = '0;
    wdata_ex         = '0;
    csr_rdata        = '0;

    load_vectors();
    if (vectors.size() == 0) begin
      $display("no test vectors were found in %s", VecFile);
      abort_run();
    end else begin
      cycle_limit = 4 * vectors.size() + 20;
      @(posedge rst_n);
      foreach (vectors[i]) begin
        @(negedge clk);
        apply_vector(vectors[i]);
        #(SettleNs);
        check_vector(vectors[i]);
      end
      // Let the last write settle
      @(negedge clk);
      if (check_count > 0) begin
        $display("all tests passed");
        $finish;
      end else begin
        $display("the vector file holds no checks");
        abort_run();
      end
    end
  end

endmodule

// File: verif/id_stage_vectors.txt
# name instr pc valid misal br_taken ex_rdy lsu_wd ex_wd csr_rd | alu_op op_a op_b req wdata csr_op rdy ill mask
# mask bits: 0 alu_op 1 op_a 2 op_b 3 req 4 wdata 5 csr_op 6 rdy 7 ill (all hex, lsu_addr_last is 1ffe)
# Immediates
addi_imm ffb00013 1000 1 0 0 1 0 0 0 0 0 fffffffb 0 0 0 1 0 c7
lui_imm 12345037 1004 1 0 0 1 0 0 0 0 0 12345000 0 0 0 1 0 c7
auipc_imm fffff017 1008 1 0 0 1 0 0 0 0 1008 fffff000 0 0 0 1 0 c7
sw_imm_1 fe002e23 100c 1 0 0 1 0 0 0 0 0 fffffffc 1 0 0 0 0 df
sw_imm_2 fe002e23 100c 1 0 0 1 0 0 0 0 0 fffffffc 1 0 0 1 0 df
# Write x5, read it back, x0 stays zero
add_wr 000002b3 1010 1 0 0 1 0 cafe0005 0 0 0 0 0 0 0 1 0 c7
sw_rd_1 0052a423 1014 1 0 0 1 0 deadbeef 0 0 cafe0005 8 1 cafe0005 0 0 0 df
sw_rd_2 0052a423 1014 1 0 0 1 0 deadbeef 0 0 cafe0005 8 1 cafe0005 0 1 0 df
rd_x0 00028033 1018 1 0 0 1 0 77777777 0 0 cafe0005 0 0 0 0 1 0 c7
x0_keep 00000033 101c 1 0 0 1 0 0 0 0 0 0 0 0 0 1 0 c7
# Load stall, then invalid slot
lw_1 0002a383 1020 1 0 0 0 1234abcd 0badbad 0 0 cafe0005 0 1 0 0 0 0 cf
lw_2 0002a383 1020 1 0 0 0 1234abcd 0badbad 0 0 cafe0005 0 1 0 0 0 0 cf
lw_3 0002a383 1020 1 0 0 1 1234abcd 0badbad 0 0 cafe0005 0 1 0 0 1 0 cf
no_valid 000003b3 1024 0 0 0 1 0 ffffffff 0 0 0 0 0 0 0 1 0 cf
rd_x7 00038033 1028 1 0 0 1 0 0 0 0 1234abcd 0 0 0 0 1 0 c7
# Branches and jumps
bne_nt fe729ce3 2000 1 0 0 1 0 0 0 b cafe0005 1234abcd 0 0 0 1 0 cf
bne_t1 fe729ce3 2000 1 0 1 0 0 0 0 b cafe0005 1234abcd 0 0 0 0 0 cf
bne_t2 fe729ce3 2000 1 0 1 0 0 0 0 0 2000 fffffff8 0 0 0 0 0 cf
bne_t3 fe729ce3 2000 1 0 1 1 0 0 0 0 2000 fffffff8 0 0 0 1 0 cf
jal_1 010001ef 3000 1 0 0 0 0 3004 0 0 3000 10 0 0 0 0 0 cf
jal_2 010001ef 3000 1 0 0 0 0 3004 0 0 3000 4 0 0 0 0 0 cf
jal_3 010001ef 3000 1 0 0 1 0 3004 0 0 3000 4 0 0 0 1 0 cf
rd_x3 00018033 3004 1 0 0 1 0 0 0 0 3004 0 0 0 0 1 0 c7
# Misaligned second half
misal_1 0042a403 3008 1 1 0 0 55555555 66666666 0 0 1ffe 4 1 0 0 0 0 cf
misal_2 0042a403 3008 1 1 0 1 55555555 66666666 0 0 1ffe 4 1 0 0 1 0 cf
rd_x8 00040033 300c 1 0 0 1 0 0 0 0 0 0 0 0 0 1 0 c7
# CSR access and illegal opcode
csr_read 300024f3 3010 1 0 0 1 0 99999999 1888 0 0 300 0 0 1 1 0 e7
csr_set 3002a573 3014 1 0 0 1 0 99999999 88 0 cafe0005 300 0 0 3 1 0 e7
rd_csr 00a48033 3018 1 0 0 1 0 0 0 0 1888 88 0 0 0 1 0 c7
csr_zimm 340ad073 301c 1 0 0 1 0 0 0 0 15 340 0 0 2 1 0 e7
illegal 0000057f 3020 1 0 0 1 0 bbbbbbbb 0 0 0 0 0 0 0 1 1 c8
rd_x10 00050033 3024 1 0 0 1 0 0 0 0 88 0 0 0 0 1 0 c7

// File: verif/tb_clk_gen.sv
`timescale 1ns/1ps
// Testbench clock and reset source.
// Clock period is twice HalfPeriodNs. Reset is active low and is
// released on the falling edge after ResetCycles rising edges.
module tb_clk_gen #(
  parameter int unsigned HalfPeriodNs = 4,
  parameter int unsigned ResetCycles  = 4
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever begin
      #(HalfPeriodNs) clk_o = ~clk_o;
    end
  end

  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    // Release away from the active edge
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule
